//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16
`define RD_MSB 15
`define RD_LSB 11
`define FUNCT_MSB 5
`define FUNCT_LSB 0
`define IMM_MSB 15
`define IMM_LSB 0
`define INDEX_MSB 25
`define INDEX_LSB 0

`define STAGE_DECODE 1
`define STAGE_EXECUTE 2
`define STAGE_MEMORY 3

`define DMEM_WORDS 64
`define RESET_PC 32'h0000_0000

`define OP_RTYPE 6'b000000
`define OP_ORI 6'b001101
`define OP_LUI 6'b001111
`define OP_LW 6'b100011
`define OP_SW 6'b101011
`define OP_BEQ 6'b000100
`define OP_JAL 6'b000011
`define FUNCT_ADD 6'b100000
`define FUNCT_SUB 6'b100010
`define FUNCT_JR 6'b001000

// operand source select, shared by decode and execute forwarding
`define FWD_NONE 2'd0
`define FWD_E 2'd1
`define FWD_M 2'd2
`define FWD_W 2'd3

`endif

//--- verilog/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;
    typedef logic signed [2:0] tCycle_t; // -1 for no use / no result

    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluNone} aluOp_e;
    typedef enum logic [1:0] {extZero, extSign, extUpper, extNone} extOp_e;
    typedef enum logic [1:0] {srcAlu, srcMem, srcPc, srcNone} regSrc_e;
    typedef enum logic [1:0] {dstRd, dstRt, dstRa, dstNone} regDst_e;
    typedef enum logic [1:0] {jumpNone, jumpIndex, jumpReg} jump_e;
    typedef enum logic [1:0] {dmNone, dmRead, dmWrite} dmOp_e;

    typedef struct packed {
        logic aluSrc; // 1 selects the extended immediate
        aluOp_e aluOp;
        extOp_e extOp;
        dmOp_e dmOp;
        regSrc_e regSrc;
        regDst_e regDst;
        logic regWrite;
        logic branch;
        logic cmpOp; // taken when (rs == rt) matches this
        jump_e jump;
        tCycle_t tuseRs;
        tCycle_t tuseRt;
        tCycle_t tnew;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t rsData;
        word_t rtData;
        logic valid;
    } deReg_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t aluResult;
        word_t rtData;
        regIdx_t dstReg;
        logic writeEn;
    } emReg_t;

    typedef struct packed {
        word_t instr;
        regIdx_t dstReg;
        word_t writeData;
        logic writeEn;
    } mwReg_t;

    // 0 means the instruction writes no register
    function automatic regIdx_t destReg(input ctrl_t c, input word_t instr);
        case (c.regDst)
            dstRd: return instr[`RD_MSB:`RD_LSB];
            dstRt: return instr[`RT_MSB:`RT_LSB];
            dstRa: return 5'd31;
            default: return 5'd0;
        endcase
    endfunction

endpackage

//--- verilog/control.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module control #(
    parameter int pipeStage = `STAGE_DECODE
) (
    input  mips_pkg::word_t instr,
    output mips_pkg::ctrl_t ctrl
);
    localparam mips_pkg::tCycle_t tNone = -3'sd1;
    localparam mips_pkg::tCycle_t aluTnew = (pipeStage == `STAGE_DECODE) ? 3'sd2 :
                                            (pipeStage == `STAGE_EXECUTE) ? 3'sd1 : 3'sd0;
    localparam mips_pkg::tCycle_t loadTnew = (pipeStage == `STAGE_DECODE) ? 3'sd3 :
                                             (pipeStage == `STAGE_EXECUTE) ? 3'sd2 :
                                             (pipeStage == `STAGE_MEMORY) ? 3'sd1 : 3'sd0;
    localparam mips_pkg::tCycle_t earlyTnew = (pipeStage == `STAGE_DECODE) ? 3'sd1 : 3'sd0;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[`OPCODE_MSB:`OPCODE_LSB];
    assign funct = instr[`FUNCT_MSB:`FUNCT_LSB];

    always_comb begin
        // nop and unknown codes keep these
        ctrl.aluSrc = 1'b0;
        ctrl.aluOp = mips_pkg::aluNone;
        ctrl.extOp = mips_pkg::extNone;
        ctrl.dmOp = mips_pkg::dmNone;
        ctrl.regSrc = mips_pkg::srcNone;
        ctrl.regDst = mips_pkg::dstNone;
        ctrl.regWrite = 1'b0;
        ctrl.branch = 1'b0;
        ctrl.cmpOp = 1'b0;
        ctrl.jump = mips_pkg::jumpNone;
        ctrl.tuseRs = tNone;
        ctrl.tuseRt = tNone;
        ctrl.tnew = tNone;
        case (opcode)
            `OP_RTYPE: begin
                if (funct == `FUNCT_ADD || funct == `FUNCT_SUB) begin
                    ctrl.aluOp = (funct == `FUNCT_ADD) ? mips_pkg::aluAdd : mips_pkg::aluSub;
                    ctrl.regSrc = mips_pkg::srcAlu;
                    ctrl.regDst = mips_pkg::dstRd;
                    ctrl.regWrite = 1'b1;
                    ctrl.tuseRs = 3'sd1;
                    ctrl.tuseRt = 3'sd1;
                    ctrl.tnew = aluTnew;
                end else if (funct == `FUNCT_JR) begin
                    ctrl.jump = mips_pkg::jumpReg;
                    ctrl.tuseRs = 3'sd0; // target needed in decode
                end
            end
            `OP_ORI, `OP_LUI: begin
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = mips_pkg::aluOr;
                ctrl.extOp = (opcode == `OP_ORI) ? mips_pkg::extZero : mips_pkg::extUpper;
                ctrl.regSrc = mips_pkg::srcAlu;
                ctrl.regDst = mips_pkg::dstRt;
                ctrl.regWrite = 1'b1;
                ctrl.tuseRs = (opcode == `OP_ORI) ? 3'sd1 : tNone;
                ctrl.tnew = (opcode == `OP_ORI) ? aluTnew : earlyTnew;
            end
            `OP_LW, `OP_SW: begin
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = mips_pkg::aluAdd;
                ctrl.extOp = mips_pkg::extSign;
                ctrl.tuseRs = 3'sd1;
                if (opcode == `OP_LW) begin
                    ctrl.dmOp = mips_pkg::dmRead;
                    ctrl.regSrc = mips_pkg::srcMem;
                    ctrl.regDst = mips_pkg::dstRt;
                    ctrl.regWrite = 1'b1;
                    ctrl.tnew = loadTnew;
                end else begin
                    ctrl.dmOp = mips_pkg::dmWrite;
                    ctrl.tuseRt = 3'sd2; // store data used in memory
                end
            end
            `OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.cmpOp = 1'b1;
                ctrl.tuseRs = 3'sd0;
                ctrl.tuseRt = 3'sd0;
            end
            `OP_JAL: begin
                ctrl.jump = mips_pkg::jumpIndex;
                ctrl.regSrc = mips_pkg::srcPc;
                ctrl.regDst = mips_pkg::dstRa;
                ctrl.regWrite = 1'b1;
                ctrl.tnew = earlyTnew;
            end
            default: begin
                ctrl.regWrite = 1'b0;
            end
        endcase
    end
endmodule

//--- verilog/fetchStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module fetchStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic redirect,
    input  mips_pkg::word_t redirectPc,
    output mips_pkg::word_t instrAddr,
    input  mips_pkg::word_t instr,
    output mips_pkg::word_t fdInstr,
    output mips_pkg::word_t fdPc
);
    mips_pkg::word_t pcReg;

    assign instrAddr = pcReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= `RESET_PC;
            fdInstr <= '0;
            fdPc <= `RESET_PC;
        end else if (!stall) begin
            pcReg <= redirect ? redirectPc : pcReg + 32'd4;
            fdInstr <= redirect ? '0 : instr; // squash, no delay slot
            fdPc <= pcReg;
        end
    end
endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  mips_pkg::word_t fdInstr,
    input  mips_pkg::word_t fdPc,
    input  logic [1:0] fwdSelRs,
    input  logic [1:0] fwdSelRt,
    input  mips_pkg::word_t fwdE,
    input  mips_pkg::word_t fwdM,
    input  mips_pkg::mwReg_t mw,
    output logic redirect,
    output mips_pkg::word_t redirectPc,
    output mips_pkg::deReg_t de
);
    mips_pkg::word_t regFile [32];
    mips_pkg::ctrl_t ctrl;
    mips_pkg::regIdx_t rs;
    mips_pkg::regIdx_t rt;
    mips_pkg::word_t rfRs;
    mips_pkg::word_t rfRt;
    mips_pkg::word_t rsVal;
    mips_pkg::word_t rtVal;
    mips_pkg::word_t pcPlus4;
    mips_pkg::word_t branchTarget;
    logic taken;

    control #(.pipeStage(`STAGE_DECODE)) decodeCtrl (.instr(fdInstr), .ctrl(ctrl));

    assign rs = fdInstr[`RS_MSB:`RS_LSB];
    assign rt = fdInstr[`RT_MSB:`RT_LSB];

    always_ff @(posedge clk) begin
        if (mw.writeEn) begin
            regFile[mw.dstReg] <= mw.writeData;
        end
    end

    // write-through read, $0 reads zero
    assign rfRs = (rs == 5'd0) ? '0 :
                  (mw.writeEn && mw.dstReg == rs) ? mw.writeData : regFile[rs];
    assign rfRt = (rt == 5'd0) ? '0 :
                  (mw.writeEn && mw.dstReg == rt) ? mw.writeData : regFile[rt];

    assign rsVal = (fwdSelRs == `FWD_E) ? fwdE : (fwdSelRs == `FWD_M) ? fwdM :
                   (fwdSelRs == `FWD_W) ? mw.writeData : rfRs;
    assign rtVal = (fwdSelRt == `FWD_E) ? fwdE : (fwdSelRt == `FWD_M) ? fwdM :
                   (fwdSelRt == `FWD_W) ? mw.writeData : rfRt;

    assign pcPlus4 = fdPc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{fdInstr[15]}}, fdInstr[`IMM_MSB:`IMM_LSB], 2'b00};
    assign taken = ctrl.branch && ((rsVal == rtVal) == ctrl.cmpOp);

    assign redirectPc = (ctrl.jump == mips_pkg::jumpReg) ? rsVal :
                        (ctrl.jump == mips_pkg::jumpIndex) ?
                        {pcPlus4[31:28], fdInstr[`INDEX_MSB:`INDEX_LSB], 2'b00} : branchTarget;
    // operands are stale while stalled
    assign redirect = !stall && (taken || ctrl.jump != mips_pkg::jumpNone);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            de <= '0;
        end else if (stall) begin
            de <= '0; // bubble
        end else begin
            de <= '{instr: fdInstr, pc: fdPc, rsData: rsVal, rtData: rtVal, valid: 1'b1};
        end
    end
endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module hazardUnit (
    input  mips_pkg::word_t fdInstr,
    input  mips_pkg::word_t deInstr,
    input  mips_pkg::word_t emInstr,
    input  mips_pkg::mwReg_t mw,
    output logic stall,
    output logic [1:0] fwdSelRs,
    output logic [1:0] fwdSelRt,
    output logic [1:0] exFwdRs,
    output logic [1:0] exFwdRt
);
    mips_pkg::ctrl_t dCtrl;
    mips_pkg::ctrl_t eCtrl;
    mips_pkg::ctrl_t mCtrl;
    mips_pkg::regIdx_t dRs;
    mips_pkg::regIdx_t dRt;
    mips_pkg::regIdx_t eDst;
    mips_pkg::regIdx_t mDst;
    mips_pkg::regIdx_t wDst;
    logic eReady;
    logic mReady;

    control #(.pipeStage(`STAGE_DECODE)) dCopy (.instr(fdInstr), .ctrl(dCtrl));
    control #(.pipeStage(`STAGE_EXECUTE)) eCopy (.instr(deInstr), .ctrl(eCtrl));
    control #(.pipeStage(`STAGE_MEMORY)) mCopy (.instr(emInstr), .ctrl(mCtrl));

    function automatic logic clash(input mips_pkg::regIdx_t src, input mips_pkg::tCycle_t tuse,
                                   input mips_pkg::regIdx_t dst, input mips_pkg::tCycle_t tnew);
        return src != 5'd0 && tuse >= 0 && dst == src && tnew > tuse;
    endfunction

    // youngest ready producer wins
    function automatic logic [1:0] pick(input mips_pkg::regIdx_t src,
                                        input mips_pkg::regIdx_t dstE, input logic readyE,
                                        input mips_pkg::regIdx_t dstM, input logic readyM,
                                        input mips_pkg::regIdx_t dstW);
        if (src == 5'd0) return `FWD_NONE;
        if (src == dstE && readyE) return `FWD_E;
        if (src == dstM && readyM) return `FWD_M;
        if (src == dstW) return `FWD_W;
        return `FWD_NONE;
    endfunction

    assign dRs = fdInstr[`RS_MSB:`RS_LSB];
    assign dRt = fdInstr[`RT_MSB:`RT_LSB];
    assign eDst = mips_pkg::destReg(eCtrl, deInstr);
    assign mDst = mips_pkg::destReg(mCtrl, emInstr);
    assign wDst = mw.writeEn ? mw.dstReg : 5'd0;
    assign eReady = eCtrl.tnew == 0;
    assign mReady = mCtrl.tnew == 0;

    assign stall = clash(dRs, dCtrl.tuseRs, eDst, eCtrl.tnew) ||
                   clash(dRs, dCtrl.tuseRs, mDst, mCtrl.tnew) ||
                   clash(dRt, dCtrl.tuseRt, eDst, eCtrl.tnew) ||
                   clash(dRt, dCtrl.tuseRt, mDst, mCtrl.tnew);

    assign fwdSelRs = pick(dRs, eDst, eReady, mDst, mReady, wDst);
    assign fwdSelRt = pick(dRt, eDst, eReady, mDst, mReady, wDst);
    assign exFwdRs = pick(deInstr[`RS_MSB:`RS_LSB], 5'd0, 1'b0, mDst, mReady, wDst);
    assign exFwdRt = pick(deInstr[`RT_MSB:`RT_LSB], 5'd0, 1'b0, mDst, mReady, wDst);
endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module executeStage (
    input  logic clk,
    input  logic rstN,
    input  mips_pkg::deReg_t de,
    input  logic [1:0] exFwdRs,
    input  logic [1:0] exFwdRt,
    input  mips_pkg::word_t fwdM,
    input  mips_pkg::mwReg_t mw,
    output mips_pkg::word_t fwdE,
    output mips_pkg::emReg_t em
);
    mips_pkg::ctrl_t ctrl;
    mips_pkg::word_t rsVal;
    mips_pkg::word_t rtVal;
    mips_pkg::word_t immExt;
    mips_pkg::word_t aluB;
    mips_pkg::word_t aluResult;
    mips_pkg::regIdx_t dst;
    logic [15:0] imm;

    control #(.pipeStage(`STAGE_EXECUTE)) exCtrl (.instr(de.instr), .ctrl(ctrl));

    assign rsVal = (exFwdRs == `FWD_M) ? fwdM : (exFwdRs == `FWD_W) ? mw.writeData : de.rsData;
    assign rtVal = (exFwdRt == `FWD_M) ? fwdM : (exFwdRt == `FWD_W) ? mw.writeData : de.rtData;

    assign imm = de.instr[`IMM_MSB:`IMM_LSB];
    assign immExt = (ctrl.extOp == mips_pkg::extZero) ? {16'h0000, imm} :
                    (ctrl.extOp == mips_pkg::extSign) ? {{16{imm[15]}}, imm} :
                    (ctrl.extOp == mips_pkg::extUpper) ? {imm, 16'h0000} : '0;
    assign aluB = ctrl.aluSrc ? immExt : rtVal;

    always_comb begin
        case (ctrl.aluOp)
            mips_pkg::aluAdd: aluResult = rsVal + aluB;
            mips_pkg::aluSub: aluResult = rsVal - aluB;
            mips_pkg::aluOr: aluResult = rsVal | aluB;
            default: aluResult = '0;
        endcase
    end

    assign fwdE = (ctrl.regSrc == mips_pkg::srcPc) ? de.pc + 32'd4 : aluResult; // jal link
    assign dst = mips_pkg::destReg(ctrl, de.instr);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            em <= '0;
        end else begin
            em <= '{instr: de.instr, pc: de.pc, aluResult: aluResult, rtData: rtVal,
                    dstReg: dst, writeEn: ctrl.regWrite && de.valid && dst != 5'd0};
        end
    end
endmodule

//--- verilog/memoryStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module memoryStage (
    input  logic clk,
    input  logic rstN,
    input  mips_pkg::emReg_t em,
    output mips_pkg::word_t fwdM,
    output mips_pkg::mwReg_t mw
);
    mips_pkg::word_t dmem [`DMEM_WORDS];
    mips_pkg::ctrl_t ctrl;
    mips_pkg::word_t storeData;
    mips_pkg::word_t wbValue;
    mips_pkg::regIdx_t rt;
    logic [$clog2(`DMEM_WORDS)-1:0] dmIdx;

    control #(.pipeStage(`STAGE_MEMORY)) memCtrl (.instr(em.instr), .ctrl(ctrl));

    assign dmIdx = em.aluResult[$clog2(`DMEM_WORDS)+1:2]; // word index, wraps
    assign rt = em.instr[`RT_MSB:`RT_LSB];
    // sw right behind a load picks up the loaded word here
    assign storeData = (mw.writeEn && mw.dstReg == rt) ? mw.writeData : em.rtData;

    assign fwdM = (ctrl.regSrc == mips_pkg::srcPc) ? em.pc + 32'd4 : em.aluResult;
    assign wbValue = (ctrl.regSrc == mips_pkg::srcMem) ? dmem[dmIdx] : fwdM;

    always_ff @(posedge clk) begin
        if (ctrl.dmOp == mips_pkg::dmWrite) begin
            dmem[dmIdx] <= storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mw <= '0;
        end else begin
            mw <= '{instr: em.instr, dstReg: em.dstReg, writeData: wbValue, writeEn: em.writeEn};
        end
    end
endmodule

//--- verilog/mipsPipe.sv
`timescale 1ns/1ns

module mipsPipe (
    input  logic clk,
    input  logic rstN,
    output mips_pkg::word_t instrAddr,
    input  mips_pkg::word_t instr,
    output logic wbEn,
    output mips_pkg::regIdx_t wbReg,
    output mips_pkg::word_t wbData,
    output mips_pkg::word_t pc
);
    mips_pkg::word_t fdInstr;
    mips_pkg::word_t fdPc;
    mips_pkg::word_t redirectPc;
    mips_pkg::word_t fwdE;
    mips_pkg::word_t fwdM;
    mips_pkg::deReg_t de;
    mips_pkg::emReg_t em;
    mips_pkg::mwReg_t mw;
    logic stall;
    logic redirect;
    logic [1:0] fwdSelRs;
    logic [1:0] fwdSelRt;
    logic [1:0] exFwdRs;
    logic [1:0] exFwdRt;

    fetchStage fetch (.clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect),
                      .redirectPc(redirectPc), .instrAddr(instrAddr), .instr(instr),
                      .fdInstr(fdInstr), .fdPc(fdPc));

    decodeStage decode (.clk(clk), .rstN(rstN), .stall(stall), .fdInstr(fdInstr), .fdPc(fdPc),
                        .fwdSelRs(fwdSelRs), .fwdSelRt(fwdSelRt), .fwdE(fwdE), .fwdM(fwdM),
                        .mw(mw), .redirect(redirect), .redirectPc(redirectPc), .de(de));

    hazardUnit hazard (.fdInstr(fdInstr), .deInstr(de.instr), .emInstr(em.instr), .mw(mw),
                       .stall(stall), .fwdSelRs(fwdSelRs), .fwdSelRt(fwdSelRt),
                       .exFwdRs(exFwdRs), .exFwdRt(exFwdRt));

    executeStage execute (.clk(clk), .rstN(rstN), .de(de), .exFwdRs(exFwdRs),
                          .exFwdRt(exFwdRt), .fwdM(fwdM), .mw(mw), .fwdE(fwdE), .em(em));

    memoryStage memory (.clk(clk), .rstN(rstN), .em(em), .fwdM(fwdM), .mw(mw));

    assign wbEn = mw.writeEn;
    assign wbReg = mw.dstReg;
    assign wbData = mw.writeData;
    assign pc = instrAddr;
endmodule

//--- dv/mipsPipe_sva.sv
`timescale 1ns/1ns

module mipsPipeSva (
    input  logic clk,
    input  logic rstN,
    input  logic wbEn,
    input  mips_pkg::regIdx_t wbReg,
    input  mips_pkg::word_t pc,
    input  logic stall,
    input  logic redirect,
    input  mips_pkg::word_t fdInstr
);
    int failCount = 0; // read by the testbench at the end

    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        wbEn |-> wbReg != 5'd0)
        else begin
            $error("writeback to register 0");
            failCount++;
        end

    pcHoldsOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(pc))
        else begin
            $error("pc moved during a stall");
            failCount++;
        end

    squashAfterRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirect |=> fdInstr == '0)
        else begin
            $error("decode instruction not squashed after a redirect");
            failCount++;
        end
endmodule

bind mipsPipe mipsPipeSva sva (.clk(clk), .rstN(rstN), .wbEn(wbEn), .wbReg(wbReg), .pc(pc),
                               .stall(stall), .redirect(redirect), .fdInstr(fdInstr));

//--- dv/mipsPipeTb.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mipsPipeTb;
    localparam int progWords = 32;
    localparam int wbTimeout = 20; // cycles allowed per writeback
    localparam int quietCycles = 8;

    logic clk;
    logic rstN;
    mips_pkg::word_t instrAddr;
    mips_pkg::word_t instr;
    logic wbEn;
    mips_pkg::regIdx_t wbReg;
    mips_pkg::word_t wbData;
    mips_pkg::word_t pc;

    mips_pkg::word_t prog [progWords];
    string expName [$];
    mips_pkg::regIdx_t expReg [$];
    mips_pkg::word_t expData [$];
    integer seed;
    mips_pkg::word_t storeVal;
    mips_pkg::word_t lastPc;

    mipsPipe DUT (.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .wbEn(wbEn),
                  .wbReg(wbReg), .wbData(wbData), .pc(pc));

    // nop past the end of the table
    assign instr = (instrAddr[31:2] < progWords) ? prog[instrAddr[6:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic mips_pkg::word_t encR(input logic [5:0] funct, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t encI(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addExpect(input string name, input mips_pkg::regIdx_t r,
                             input mips_pkg::word_t d);
        expName.push_back(name);
        expReg.push_back(r);
        expData.push_back(d);
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic waitWriteback(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wbEn !== 1'b1 && cycles < wbTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (wbEn !== 1'b1) begin
            failRun($sformatf("timeout: no writeback seen for %s", name));
        end
    endtask

    task automatic buildProgram();
        for (int i = 0; i < progWords; i++) begin
            prog[i] = '0;
        end
        prog[0] = encI(`OP_ORI, 5'd1, 5'd0, 16'h1234);
        prog[1] = encI(`OP_LUI, 5'd2, 5'd0, 16'hABCD);
        prog[2] = encR(`FUNCT_ADD, 5'd3, 5'd1, 5'd2); // forwards from E and M
        prog[3] = encR(`FUNCT_SUB, 5'd4, 5'd3, 5'd1);
        prog[4] = encI(`OP_LUI, 5'd5, 5'd0, storeVal[31:16]);
        prog[5] = encI(`OP_ORI, 5'd5, 5'd5, storeVal[15:0]);
        prog[6] = encI(`OP_SW, 5'd5, 5'd0, 16'd8);
        prog[7] = encI(`OP_LW, 5'd6, 5'd0, 16'd8);
        prog[8] = encR(`FUNCT_ADD, 5'd7, 5'd6, 5'd1); // load-use stall
        prog[9] = encI(`OP_BEQ, 5'd1, 5'd1, 16'd1); // taken, skips 10
        prog[10] = encI(`OP_ORI, 5'd8, 5'd0, 16'h0BAD);
        prog[11] = encI(`OP_BEQ, 5'd2, 5'd1, 16'd1); // not taken
        prog[12] = encI(`OP_ORI, 5'd9, 5'd0, 16'h0055);
        prog[13] = {`OP_JAL, 26'd16};
        prog[14] = encI(`OP_ORI, 5'd10, 5'd0, 16'h0077); // return point
        prog[15] = encI(`OP_BEQ, 5'd0, 5'd0, 16'd4); // hop over subroutine to 20
        prog[16] = encI(`OP_ORI, 5'd11, 5'd0, 16'h0011);
        prog[17] = encR(`FUNCT_JR, 5'd0, 5'd31, 5'd0);
        prog[18] = encI(`OP_ORI, 5'd12, 5'd0, 16'hDEAD);
        prog[21] = 32'hFC00_0000; // unknown opcode
        prog[22] = encI(`OP_ORI, 5'd13, 5'd0, 16'h0099);
        prog[23] = encI(`OP_ORI, 5'd0, 5'd0, 16'h0123); // targets $0, no writeback

        addExpect("ori r1", 5'd1, 32'h0000_1234);
        addExpect("lui r2", 5'd2, 32'hABCD_0000);
        addExpect("add r3", 5'd3, 32'hABCD_1234);
        addExpect("sub r4", 5'd4, 32'hABCD_0000);
        addExpect("lui r5", 5'd5, {storeVal[31:16], 16'h0000});
        addExpect("ori r5", 5'd5, storeVal);
        addExpect("lw r6", 5'd6, storeVal);
        addExpect("add after lw", 5'd7, storeVal + 32'h0000_1234);
        addExpect("ori after beq", 5'd9, 32'h0000_0055);
        addExpect("jal link", 5'd31, 32'h0000_0038);
        addExpect("ori in callee", 5'd11, 32'h0000_0011);
        addExpect("ori after jr", 5'd10, 32'h0000_0077);
        addExpect("ori after unknown", 5'd13, 32'h0000_0099);
    endtask

    initial begin
        rstN = 1'b0;
        seed = 32'h13dd8fdd;
        storeVal = $random(seed);
        buildProgram();
        repeat (3) @(posedge clk);
        #10 rstN = 1'b1;
        checkValue("pc after reset", `RESET_PC, pc);
        checkValue("wbEn after reset", 32'd0, 32'(wbEn));

        for (int i = 0; i < expName.size(); i++) begin
            waitWriteback(expName[i]);
            checkValue({expName[i], " reg"}, 32'(expReg[i]), 32'(wbReg));
            checkValue({expName[i], " data"}, expData[i], wbData);
        end

        // skipped, nop and unknown instructions must stay silent
        lastPc = pc;
        repeat (quietCycles) begin
            @(negedge clk);
            checkValue("no extra writeback", 32'd0, 32'(wbEn));
            checkValue("pc step", lastPc + 32'd4, pc); // straight-line nops
            lastPc = pc;
        end

        if (DUT.sva.failCount != 0) begin
            failRun("bound assertions reported failures");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end
endmodule

//--- compile.f
+incdir+include
verilog/mips_pkg.sv
verilog/control.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsPipe.sv
dv/mipsPipe_sva.sv
dv/mipsPipeTb.sv
